// ==== Makefile ====
# Verilator build for the TLB testbench

VERILATOR ?= verilator
TOP       ?= tlb_tb
SEED      ?= 0
FLAGS     ?=
BUILD     ?= obj_dir
FILELIST  ?= src.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD) $(FLAGS)

# a $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)

// ==== include/tlb_ref_model.svh ====
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// shadow copy of the table
tlb_entry_t model_tlb [TLBNUM];

function automatic void model_reset();
    for (int i = 0; i < TLBNUM; i++) begin
        model_tlb[i].e = 1'b0;
    end
endfunction

function automatic void model_write(int unsigned idx, tlb_entry_t ent);
    model_tlb[idx] = ent;
endfunction

// a vpn2 covers two pages, so ps - 12 low vpn2 bits fall inside the page
function automatic logic model_vpn_eq(tlb_entry_t ent, logic [18:0] vpn2);
    int          ignore;
    logic [18:0] mask;
    ignore = int'(ent.ps) - 12;
    mask   = {19{1'b1}} << ignore;
    return (ent.vpn2 & mask) == (vpn2 & mask);
endfunction

function automatic void model_inv(logic [2:0] op, logic [31:0] vaddr, logic [9:0] asid);
    logic g;
    logic aeq;
    logic va;
    logic sel;
    for (int i = 0; i < TLBNUM; i++) begin
        g   = model_tlb[i].g;
        aeq = model_tlb[i].asid == asid;
        va  = model_vpn_eq(model_tlb[i], vaddr[31:13]);
        case (op)
            3'd0, 3'd1: sel = 1'b1;
            3'd2: sel = g;
            3'd3: sel = !g;
            3'd4: sel = !g && aeq;
            3'd5: sel = !g && aeq && va;
            3'd6: sel = (g || aeq) && va;
            default: sel = 1'b0;
        endcase
        if (sel) begin
            model_tlb[i].e = 1'b0;
        end
    end
endfunction

// lowest matching index wins
// odd_sel holds vaddr bits 21 and 12
function automatic tlb_hit_t model_match(logic [18:0] vpn2, logic [9:0] asid,
                                         logic [1:0] odd_sel);
    tlb_hit_t   res;
    tlb_entry_t ent;
    logic       odd;
    res = '0;
    for (int i = TLBNUM - 1; i >= 0; i--) begin
        ent = model_tlb[i];
        if (ent.e && model_vpn_eq(ent, vpn2) && (ent.g || ent.asid == asid)) begin
            odd       = (ent.ps == PS_2M) ? odd_sel[1] : odd_sel[0];
            res.hit   = 1'b1;
            res.index = TLB_IDX_W'(i);
            res.ps    = ent.ps;
            res.page  = odd ? ent.page1 : ent.page0;
        end
    end
    return res;
endfunction

function automatic logic model_win(dmw_cfg_t cfg, search_req_t req);
    return ((cfg.plv0 && req.plv == 2'd0) || (cfg.plv3 && req.plv == 2'd3))
           && req.vaddr[31:29] == cfg.vseg;
endfunction

function automatic search_rsp_t model_translate(search_req_t req, logic [1:0] ad_mode,
                                                logic [1:0] da_mat, dmw_cfg_t dmw0,
                                                dmw_cfg_t dmw1);
    search_rsp_t rsp;
    tlb_hit_t    th;
    rsp       = '0;
    rsp.valid = 1'b1;
    th = model_match(req.vaddr[31:13], req.asid, {req.vaddr[21], req.vaddr[12]});
    if (ad_mode == AD_DIRECT) begin
        rsp.paddr = req.vaddr;
        rsp.mat   = da_mat;
    end else if (model_win(dmw0, req)) begin
        rsp.paddr = {dmw0.pseg, req.vaddr[28:0]};
        rsp.mat   = dmw0.mat;
    end else if (model_win(dmw1, req)) begin
        rsp.paddr = {dmw1.pseg, req.vaddr[28:0]};
        rsp.mat   = dmw1.mat;
    end else begin
        rsp.paddr = (th.ps == PS_2M) ? {th.page.pfn[19:9], req.vaddr[20:0]} :
                                       {th.page.pfn, req.vaddr[11:0]};
        rsp.mat   = th.page.mat;
        if (!th.hit) begin
            rsp.exception[EXC_REFILL] = 1'b1;
        end else if (!th.page.v) begin
            if (req.mem_type == MEM_LOAD) begin
                rsp.exception[EXC_PIL] = 1'b1;
            end else if (req.mem_type == MEM_STORE) begin
                rsp.exception[EXC_PIS] = 1'b1;
            end else begin
                rsp.exception[EXC_PIF] = 1'b1;
            end
        end else if (req.plv > th.page.plv) begin
            rsp.exception[EXC_PPI] = 1'b1;
        end else if (req.mem_type == MEM_STORE && !th.page.d) begin
            rsp.exception[EXC_PME] = 1'b1;
        end
    end
    return rsp;
endfunction

`endif

// ==== dv/tlb_tb.sv ====
`timescale 1ns/100ps

module tlb_tb
    import tlb_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;

    logic                 clk;
    logic                 reset;
    logic [1:0]           ad_mode;
    logic [1:0]           da_mat;
    logic                 s0_en;
    logic                 s1_en;
    search_req_t          s0_req;
    search_req_t          s1_req;
    search_rsp_t          s0_rsp;
    search_rsp_t          s1_rsp;
    dmw_cfg_t             dmw0;
    dmw_cfg_t             dmw1;
    logic                 we;
    logic                 fill_mode;
    logic [TLB_IDX_W-1:0] w_index;
    logic [TLB_IDX_W-1:0] f_index;
    tlb_entry_t           w_entry;
    logic [TLB_IDX_W-1:0] r_index;
    tlb_entry_t           r_entry;
    logic [18:0]          s_vpn2;
    logic [9:0]           s_asid;
    logic                 s_hit;
    logic [TLB_IDX_W-1:0] s_index;
    logic                 inv;
    logic [2:0]           inv_op;
    logic [31:0]          inv_vaddr;
    logic [9:0]           inv_asid;

    logic                 rd_chk;
    logic                 srch_chk;
    logic                 armed = 1'b0;
    search_rsp_t          exp0;
    search_rsp_t          exp1;
    int unsigned          cycles = 0;
    logic [18:0]          vpn_pool [8];

    `include "tlb_ref_model.svh"

    tlb_top i_tlb_top (
        .clk       (clk),
        .reset     (reset),
        .ad_mode   (ad_mode),
        .da_mat    (da_mat),
        .s0_en     (s0_en),
        .s1_en     (s1_en),
        .s0_req    (s0_req),
        .s1_req    (s1_req),
        .s0_rsp    (s0_rsp),
        .s1_rsp    (s1_rsp),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .we        (we),
        .fill_mode (fill_mode),
        .w_index   (w_index),
        .f_index   (f_index),
        .w_entry   (w_entry),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .s_vpn2    (s_vpn2),
        .s_asid    (s_asid),
        .s_hit     (s_hit),
        .s_index   (s_index),
        .inv       (inv),
        .inv_op    (inv_op),
        .inv_vaddr (inv_vaddr),
        .inv_asid  (inv_asid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(string name, logic [127:0] exp, logic [127:0] act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // paddr and mat carry no meaning on a refill
    task automatic check_rsp(string port, search_rsp_t exp, search_rsp_t act);
        check({port, " valid"}, 128'(exp.valid), 128'(act.valid));
        check({port, " exception"}, 128'(exp.exception), 128'(act.exception));
        if (!exp.exception[EXC_REFILL]) begin
            check({port, " paddr"}, 128'(exp.paddr), 128'(act.paddr));
            check({port, " mat"}, 128'(exp.mat), 128'(act.mat));
        end
    endtask

    // outputs seen at an edge belong to the inputs of the edge before
    always @(posedge clk) begin : compare
        tlb_hit_t srch;
        if (armed) begin
            check_rsp("s0", exp0, s0_rsp);
            check_rsp("s1", exp1, s1_rsp);
            if (rd_chk) begin
                check("read entry", 128'(model_tlb[r_index]), 128'(r_entry));
            end
            if (srch_chk) begin
                srch = model_match(s_vpn2, s_asid, 2'b00);
                check("search hit", 128'(srch.hit), 128'(s_hit));
                if (srch.hit) begin
                    check("search index", 128'(srch.index), 128'(s_index));
                end
            end
        end
        if (reset) begin
            exp0  = '0;
            exp1  = '0;
            armed = 1'b1;
            model_reset();
        end else begin
            if (s0_en) begin
                exp0 = model_translate(s0_req, ad_mode, da_mat, dmw0, dmw1);
            end else begin
                exp0.valid = 1'b0;
            end
            if (s1_en) begin
                exp1 = model_translate(s1_req, ad_mode, da_mat, dmw0, dmw1);
            end else begin
                exp1.valid = 1'b0;
            end
            // a write lands after the invalidate
            if (inv) begin
                model_inv(inv_op, inv_vaddr, inv_asid);
            end
            if (we) begin
                model_write(32'(fill_mode ? f_index : w_index), w_entry);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic tlb_page_t rand_page();
        tlb_page_t p;
        p.pfn = 20'($urandom);
        p.mat = 2'($urandom);
        p.plv = 2'($urandom);
        p.d   = 1'($urandom);
        p.v   = ($urandom % 8) != 0;
        return p;
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t ent;
        ent.vpn2  = vpn_pool[3'($urandom)];
        ent.asid  = 10'(1 + $urandom % 3);
        ent.ps    = (($urandom % 2) == 1) ? PS_2M : PS_4K;
        ent.g     = ($urandom % 4) == 0;
        ent.e     = ($urandom % 8) != 0;
        ent.page0 = rand_page();
        ent.page1 = rand_page();
        return ent;
    endfunction

    // mostly pool addresses so lookups hit
    function automatic logic [31:0] rand_vaddr();
        logic [18:0] vpn2;
        vpn2 = (($urandom % 8) == 0) ? 19'($urandom) : vpn_pool[3'($urandom)];
        return {vpn2, 13'($urandom)};
    endfunction

    function automatic search_req_t rand_req();
        search_req_t req;
        req.vaddr    = rand_vaddr();
        req.asid     = 10'(1 + $urandom % 3);
        req.plv      = 2'($urandom);
        req.mem_type = 2'($urandom % 3);
        return req;
    endfunction

    function automatic search_req_t window_req();
        search_req_t req;
        req = rand_req();
        req.vaddr[31:29] = (($urandom % 2) == 1) ? 3'd4 : 3'd5;
        return req;
    endfunction

    function automatic dmw_cfg_t window_cfg(logic plv0, logic plv3, logic [2:0] vseg);
        dmw_cfg_t cfg;
        cfg.plv0 = plv0;
        cfg.plv3 = plv3;
        cfg.mat  = 2'($urandom);
        cfg.vseg = vseg;
        cfg.pseg = 3'($urandom);
        return cfg;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        s0_en    <= 1'b0;
        s1_en    <= 1'b0;
        we       <= 1'b0;
        inv      <= 1'b0;
        rd_chk   <= 1'b0;
        srch_chk <= 1'b0;
    endtask

    // the unused index gets noise
    task automatic write_entry(logic [TLB_IDX_W-1:0] idx, tlb_entry_t ent, logic fill);
        next_cycle();
        we        <= 1'b1;
        fill_mode <= fill;
        w_index   <= fill ? TLB_IDX_W'($urandom) : idx;
        f_index   <= fill ? idx : TLB_IDX_W'($urandom);
        w_entry   <= ent;
    endtask

    task automatic fill_table();
        for (int i = 0; i < TLBNUM; i++) begin
            write_entry(TLB_IDX_W'(i), rand_entry(), i[0]);
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < TLBNUM; i++) begin
            next_cycle();
            r_index <= TLB_IDX_W'(i);
            rd_chk  <= 1'b1;
        end
    endtask

    task automatic lookup(logic en0, logic en1, search_req_t r0, search_req_t r1);
        next_cycle();
        s0_en  <= en0;
        s1_en  <= en1;
        s0_req <= r0;
        s1_req <= r1;
    endtask

    task automatic search(logic [18:0] vpn2, logic [9:0] asid);
        next_cycle();
        s_vpn2   <= vpn2;
        s_asid   <= asid;
        srch_chk <= 1'b1;
    endtask

    task automatic invalidate(logic [2:0] op, logic [31:0] vaddr, logic [9:0] asid);
        next_cycle();
        inv       <= 1'b1;
        inv_op    <= op;
        inv_vaddr <= vaddr;
        inv_asid  <= asid;
    endtask

    // random enables with the odd write underneath
    task automatic random_traffic();
        next_cycle();
        s0_en  <= ($urandom % 4) != 0;
        s1_en  <= ($urandom % 4) != 0;
        s0_req <= rand_req();
        s1_req <= rand_req();
        if (($urandom % 8) == 0) begin
            we        <= 1'b1;
            fill_mode <= 1'b0;
            w_index   <= TLB_IDX_W'($urandom);
            w_entry   <= rand_entry();
        end
    endtask

    initial begin
        tlb_entry_t ent;
        dmw_cfg_t   win0;
        dmw_cfg_t   win1;
        void'($urandom(32'ha2b5));
        reset     = 1'b1;
        ad_mode   = AD_DIRECT;
        da_mat    = 2'd0;
        s0_en     = 1'b0;
        s1_en     = 1'b0;
        s0_req    = '0;
        s1_req    = '0;
        dmw0      = '0;
        dmw1      = '0;
        we        = 1'b0;
        fill_mode = 1'b0;
        w_index   = '0;
        f_index   = '0;
        w_entry   = '0;
        r_index   = '0;
        s_vpn2    = '0;
        s_asid    = '0;
        inv       = 1'b0;
        inv_op    = 3'd0;
        inv_vaddr = '0;
        inv_asid  = '0;
        rd_chk    = 1'b0;
        srch_chk  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            vpn_pool[i] = 19'($urandom);
        end
        // two pool pages inside the window segments
        vpn_pool[0][18:16] = 3'd4;
        vpn_pool[1][18:16] = 3'd5;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        fill_table();
        read_all();

        // direct mode ignores windows and table
        ad_mode <= AD_DIRECT;
        dmw0    <= window_cfg(1'b1, 1'b1, 3'd0);
        for (int i = 0; i < 60; i++) begin
            if (i % 20 == 0) begin
                da_mat <= 2'($urandom);
            end
            lookup(1'b1, 1'b1, rand_req(), rand_req());
        end

        // plv 1 and 2 requests fall through to the table
        ad_mode <= AD_MAPPED;
        for (int k = 0; k < 4; k++) begin
            win0 = window_cfg(1'b1, 1'b0, 3'd4);
            win1 = window_cfg(k[0], 1'b1, k[1] ? 3'd4 : 3'd5);
            // distinct segments so the window order shows in paddr
            win1.pseg = ~win0.pseg;
            dmw0 <= win0;
            dmw1 <= win1;
            for (int i = 0; i < 25; i++) begin
                lookup(1'b1, 1'b1, window_req(), window_req());
            end
        end

        dmw0 <= '0;
        dmw1 <= '0;
        for (int i = 0; i < 400; i++) begin
            random_traffic();
        end

        for (int op = 0; op < 8; op++) begin
            fill_table();
            invalidate(3'(op), rand_vaddr(), 10'(1 + $urandom % 3));
            for (int v = 0; v < 8; v++) begin
                for (int a = 1; a <= 3; a++) begin
                    search(vpn_pool[v], 10'(a));
                end
            end
            for (int i = 0; i < 16; i++) begin
                lookup(1'b1, 1'b1, rand_req(), rand_req());
            end
            read_all();
        end

        // write and invalidate-all in one cycle
        ent   = rand_entry();
        ent.e = 1'b1;
        next_cycle();
        we        <= 1'b1;
        fill_mode <= 1'b0;
        w_index   <= TLB_IDX_W'(5);
        w_entry   <= ent;
        inv       <= 1'b1;
        inv_op    <= 3'd0;
        read_all();

        repeat (3) next_cycle();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
verilog/tlb_pkg.sv
verilog/tlb_entry_array.sv
verilog/tlb_match.sv
verilog/tlb_dmw_map.sv
verilog/tlb_result_stage.sv
verilog/tlb_top.sv
dv/tlb_tb.sv

// ==== verilog/tlb_dmw_map.sv ====
`timescale 1ns/100ps

module tlb_dmw_map
    import tlb_pkg::*;
(
    input  logic [31:0] vaddr,
    input  logic [1:0]  plv,
    input  dmw_cfg_t    dmw0,
    input  dmw_cfg_t    dmw1,
    output dmw_hit_t    result
);

    logic hit0;
    logic hit1;

    function automatic logic win_hit(dmw_cfg_t cfg, logic [1:0] cur_plv, logic [2:0] seg);
        logic plv_ok;
        plv_ok = (cfg.plv0 && cur_plv == 2'd0) || (cfg.plv3 && cur_plv == 2'd3);
        return plv_ok && seg == cfg.vseg;
    endfunction

    assign hit0 = win_hit(dmw0, plv, vaddr[31:29]);
    assign hit1 = win_hit(dmw1, plv, vaddr[31:29]);

    // window 0 first
    always_comb begin
        result.hit = hit0 || hit1;
        if (hit0) begin
            result.paddr = {dmw0.pseg, vaddr[28:0]};
            result.mat   = dmw0.mat;
        end else begin
            result.paddr = {dmw1.pseg, vaddr[28:0]};
            result.mat   = dmw1.mat;
        end
    end

endmodule

// ==== verilog/tlb_entry_array.sv ====
`timescale 1ns/100ps

module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    we,
    input  logic                    fill_mode,
    input  logic [TLB_IDX_W-1:0]    w_index,
    input  logic [TLB_IDX_W-1:0]    f_index,
    input  tlb_entry_t              w_entry,
    input  logic                    inv,
    input  logic [2:0]              inv_op,
    input  logic [31:0]             inv_vaddr,
    input  logic [9:0]              inv_asid,
    input  logic [TLB_IDX_W-1:0]    r_index,
    output tlb_entry_t              r_entry,
    output tlb_entry_t [TLBNUM-1:0] entries
);

    logic [TLB_IDX_W-1:0]    wr_idx;
    tlb_entry_t [TLBNUM-1:0] store_q;
    logic [TLBNUM-1:0]       e_q;
    logic [TLBNUM-1:0]       asid_eq;
    logic [TLBNUM-1:0]       va_eq;
    logic [TLBNUM-1:0]       inv_sel;

    assign wr_idx = fill_mode ? f_index : w_index;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_cmp
        assign asid_eq[i] = store_q[i].asid == inv_asid;
        assign va_eq[i]   = vpn2_hit(store_q[i], inv_vaddr[31:13]);
    end

    // invtlb selection per entry
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            case (inv_op)
                3'd0, 3'd1: inv_sel[i] = 1'b1;
                3'd2: inv_sel[i] = store_q[i].g;
                3'd3: inv_sel[i] = !store_q[i].g;
                3'd4: inv_sel[i] = !store_q[i].g && asid_eq[i];
                3'd5: inv_sel[i] = !store_q[i].g && asid_eq[i] && va_eq[i];
                3'd6: inv_sel[i] = (store_q[i].g || asid_eq[i]) && va_eq[i];
                default: inv_sel[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            store_q[wr_idx] <= w_entry;
        end
    end

    // write beats invalidate on the same entry
    always_ff @(posedge clk) begin
        if (reset) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (we && wr_idx == TLB_IDX_W'(i)) begin
                    e_q[i] <= w_entry.e;
                end else if (inv && inv_sel[i]) begin
                    e_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            entries[i]   = store_q[i];
            entries[i].e = e_q[i];
        end
    end

    assign r_entry = entries[r_index];

endmodule

// ==== verilog/tlb_match.sv ====
`timescale 1ns/100ps

module tlb_match
    import tlb_pkg::*;
(
    input  tlb_entry_t [TLBNUM-1:0] entries,
    input  logic [18:0]             vpn2,
    input  logic [9:0]              asid,
    input  logic [1:0]              odd_sel,
    output tlb_hit_t                result
);

    logic [TLBNUM-1:0]    match;
    logic [TLB_IDX_W-1:0] idx;
    tlb_entry_t           sel;
    logic                 odd;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_match
        assign match[i] = entries[i].e
                       && vpn2_hit(entries[i], vpn2)
                       && (entries[i].g || entries[i].asid == asid);
    end

    // lowest index wins
    always_comb begin
        idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                idx = TLB_IDX_W'(i);
            end
        end
    end

    assign sel = entries[idx];

    // odd half-page bit depends on page size
    assign odd = (sel.ps == PS_2M) ? odd_sel[1] : odd_sel[0];

    always_comb begin
        result.hit   = |match;
        result.index = idx;
        result.ps    = sel.ps;
        result.page  = odd ? sel.page1 : sel.page0;
    end

endmodule

// ==== verilog/tlb_pkg.sv ====
package tlb_pkg;

    localparam int TLBNUM    = 16;
    localparam int TLB_IDX_W = $clog2(TLBNUM);

    // legal page sizes
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_2M = 6'd21;

    localparam logic [1:0] MEM_LOAD  = 2'd0;
    localparam logic [1:0] MEM_STORE = 2'd1;
    localparam logic [1:0] MEM_FETCH = 2'd2;

    // ad_mode is {pg, da}
    localparam logic [1:0] AD_DIRECT = 2'b01;
    localparam logic [1:0] AD_MAPPED = 2'b10;

    // one-hot exception bit positions
    localparam int EXC_REFILL = 0;
    localparam int EXC_PIL    = 1;
    localparam int EXC_PIS    = 2;
    localparam int EXC_PIF    = 3;
    localparam int EXC_PPI    = 4;
    localparam int EXC_PME    = 5;

    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        g;
        logic        e;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic [9:0]  asid;
        logic [1:0]  plv;
        logic [1:0]  mem_type;
    } search_req_t;

    typedef struct packed {
        logic                 hit;
        logic [TLB_IDX_W-1:0] index;
        logic [5:0]           ps;
        tlb_page_t            page;
    } tlb_hit_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] paddr;
        logic [1:0]  mat;
    } dmw_hit_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic [1:0]  mat;
        logic [5:0]  exception;
    } search_rsp_t;

    // vpn2 compare, 2M pages only look at the upper ten bits
    function automatic logic vpn2_hit(tlb_entry_t ent, logic [18:0] vpn2);
        if (ent.ps == PS_2M) begin
            return ent.vpn2[18:9] == vpn2[18:9];
        end
        return ent.vpn2 == vpn2;
    endfunction

endpackage

// ==== verilog/tlb_result_stage.sv ====
`timescale 1ns/100ps

module tlb_result_stage
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  search_req_t req,
    input  logic [1:0]  ad_mode,
    input  logic [1:0]  da_mat,
    input  tlb_hit_t    tlb_res,
    input  dmw_hit_t    dmw_res,
    output search_rsp_t rsp
);

    logic        valid_q;
    search_req_t req_q;
    logic [1:0]  mode_q;
    logic [1:0]  da_mat_q;
    tlb_hit_t    tlb_q;
    dmw_hit_t    dmw_q;
    logic [31:0] tlb_paddr;
    logic [5:0]  exc;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= en;
        end
    end

    // direct mode after reset so the response reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q    <= '0;
            mode_q   <= AD_DIRECT;
            da_mat_q <= '0;
        end else if (en) begin
            req_q    <= req;
            mode_q   <= ad_mode;
            da_mat_q <= da_mat;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            tlb_q <= tlb_res;
            dmw_q <= dmw_res;
        end
    end

    assign tlb_paddr = (tlb_q.ps == PS_2M) ?
                       {tlb_q.page.pfn[19:9], req_q.vaddr[20:0]} :
                       {tlb_q.page.pfn, req_q.vaddr[11:0]};

    // exception priority, only when the table is used
    always_comb begin
        exc = '0;
        if (mode_q != AD_DIRECT && !dmw_q.hit) begin
            if (!tlb_q.hit) begin
                exc[EXC_REFILL] = 1'b1;
            end else if (!tlb_q.page.v) begin
                if (req_q.mem_type == MEM_LOAD) begin
                    exc[EXC_PIL] = 1'b1;
                end else if (req_q.mem_type == MEM_STORE) begin
                    exc[EXC_PIS] = 1'b1;
                end else begin
                    exc[EXC_PIF] = 1'b1;
                end
            end else if (req_q.plv > tlb_q.page.plv) begin
                exc[EXC_PPI] = 1'b1;
            end else if (req_q.mem_type == MEM_STORE && !tlb_q.page.d) begin
                exc[EXC_PME] = 1'b1;
            end
        end
    end

    always_comb begin
        rsp.valid     = valid_q;
        rsp.exception = exc;
        if (mode_q == AD_DIRECT) begin
            rsp.paddr = req_q.vaddr;
            rsp.mat   = da_mat_q;
        end else if (dmw_q.hit) begin
            rsp.paddr = dmw_q.paddr;
            rsp.mat   = dmw_q.mat;
        end else begin
            rsp.paddr = tlb_paddr;
            rsp.mat   = tlb_q.page.mat;
        end
    end

endmodule

// ==== verilog/tlb_top.sv ====
`timescale 1ns/100ps

module tlb_top
    import tlb_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [1:0]           ad_mode,
    input  logic [1:0]           da_mat,
    // fetch and data search ports
    input  logic                 s0_en,
    input  logic                 s1_en,
    input  search_req_t          s0_req,
    input  search_req_t          s1_req,
    output search_rsp_t          s0_rsp,
    output search_rsp_t          s1_rsp,
    input  dmw_cfg_t             dmw0,
    input  dmw_cfg_t             dmw1,
    // write and fill
    input  logic                 we,
    input  logic                 fill_mode,
    input  logic [TLB_IDX_W-1:0] w_index,
    input  logic [TLB_IDX_W-1:0] f_index,
    input  tlb_entry_t           w_entry,
    input  logic [TLB_IDX_W-1:0] r_index,
    output tlb_entry_t           r_entry,
    // tlbsrch
    input  logic [18:0]          s_vpn2,
    input  logic [9:0]           s_asid,
    output logic                 s_hit,
    output logic [TLB_IDX_W-1:0] s_index,
    // invtlb
    input  logic                 inv,
    input  logic [2:0]           inv_op,
    input  logic [31:0]          inv_vaddr,
    input  logic [9:0]           inv_asid
);

    tlb_entry_t [TLBNUM-1:0] entries;
    tlb_hit_t                m0_res;
    tlb_hit_t                m1_res;
    tlb_hit_t                ms_res;
    dmw_hit_t                d0_res;
    dmw_hit_t                d1_res;

    tlb_entry_array i_array (
        .clk       (clk),
        .reset     (reset),
        .we        (we),
        .fill_mode (fill_mode),
        .w_index   (w_index),
        .f_index   (f_index),
        .w_entry   (w_entry),
        .inv       (inv),
        .inv_op    (inv_op),
        .inv_vaddr (inv_vaddr),
        .inv_asid  (inv_asid),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .entries   (entries)
    );

    tlb_match m0 (
        .entries (entries),
        .vpn2    (s0_req.vaddr[31:13]),
        .asid    (s0_req.asid),
        .odd_sel ({s0_req.vaddr[21], s0_req.vaddr[12]}),
        .result  (m0_res)
    );

    tlb_match m1 (
        .entries (entries),
        .vpn2    (s1_req.vaddr[31:13]),
        .asid    (s1_req.asid),
        .odd_sel ({s1_req.vaddr[21], s1_req.vaddr[12]}),
        .result  (m1_res)
    );

    // tlbsrch only needs hit and index
    tlb_match ms (
        .entries (entries),
        .vpn2    (s_vpn2),
        .asid    (s_asid),
        .odd_sel (2'b00),
        .result  (ms_res)
    );

    assign s_hit   = ms_res.hit;
    assign s_index = ms_res.index;

    tlb_dmw_map i_dmw0 (
        .vaddr  (s0_req.vaddr),
        .plv    (s0_req.plv),
        .dmw0   (dmw0),
        .dmw1   (dmw1),
        .result (d0_res)
    );

    tlb_dmw_map i_dmw1 (
        .vaddr  (s1_req.vaddr),
        .plv    (s1_req.plv),
        .dmw0   (dmw0),
        .dmw1   (dmw1),
        .result (d1_res)
    );

    tlb_result_stage i_res0 (
        .clk     (clk),
        .reset   (reset),
        .en      (s0_en),
        .req     (s0_req),
        .ad_mode (ad_mode),
        .da_mat  (da_mat),
        .tlb_res (m0_res),
        .dmw_res (d0_res),
        .rsp     (s0_rsp)
    );

    tlb_result_stage i_res1 (
        .clk     (clk),
        .reset   (reset),
        .en      (s1_en),
        .req     (s1_req),
        .ad_mode (ad_mode),
        .da_mat  (da_mat),
        .tlb_res (m1_res),
        .dmw_res (d1_res),
        .rsp     (s1_rsp)
    );

endmodule
